/* hw/display_cmd_pkg.sv */
// Display command set
// Op-codes, operand layout and sprite setup
package display_cmd_pkg;

    // Op-codes from the SPI peripheral
    localparam logic [7:0] op_clear_buffer = 8'h10;
    localparam logic [7:0] op_assign_color = 8'h11;
    localparam logic [7:0] op_draw_sprite  = 8'h12;
    localparam logic [7:0] op_show_buffer  = 8'h14;

    // Operand field widths
    localparam int coord_bits       = 10;
    localparam int color_count_bits = 5;
    localparam int offset_bits      = 4;

    // Operand positions, counted from 1
    localparam logic [15:0] color_operand_count = 16'd4;  // Last byte of assign color
    localparam logic [15:0] setup_operand_count = 16'd8;  // Sprite data follows this one

    // Sprite header as assembled from operands 1 to 8
    typedef struct packed {
        logic [coord_bits-1:0]       x;
        logic [coord_bits-1:0]       y;
        logic [coord_bits-1:0]       width;
        logic [color_count_bits-1:0] total_colors;
        logic [offset_bits-1:0]      palette_offset;
    } sprite_setup_t;

endpackage

/* hw/display_pixel_pkg.sv */
// Pixel and color types
package display_pixel_pkg;

    // 10-bit color, luma on top
    typedef struct packed {
        logic [3:0] luma;
        logic [2:0] cb;
        logic [2:0] cr;
    } color_t;

    typedef logic [3:0] palette_index_t;

    typedef logic [9:0] coord_t;

    // Packing density of sprite data
    // Fewer colors means more pixels per byte
    function automatic logic [2:0] bits_per_pixel(input logic [4:0] total_colors);
        logic [2:0] bpp;
        if (total_colors <= 5'd2) begin
            bpp = 3'd1;
        end else if (total_colors <= 5'd4) begin
            bpp = 3'd2;
        end else begin
            bpp = 3'd4;
        end
        return bpp;
    endfunction

endpackage

/* hw/display_if.sv */
// Internal display buses

// Decoder to sprite engine
interface sprite_if;
    logic                          setup_valid;
    display_cmd_pkg::sprite_setup_t setup;
    logic                          data_valid;
    logic [7:0]                    data;

    modport decoder (output setup_valid, setup, data_valid, data);
    modport engine (input setup_valid, setup, data_valid, data);
endinterface

// Sprite engine to buffer manager, one pixel per pulse
interface pixel_write_if;
    logic                              write_enable;
    display_pixel_pkg::coord_t         x;
    display_pixel_pkg::coord_t         y;
    display_pixel_pkg::palette_index_t index;

    modport source (output write_enable, x, y, index);
    modport sink (input write_enable, x, y, index);
endinterface

/* hw/command_decoder.sv */
// Command decoder
module command_decoder (
    input  logic                              clock_in,
    input  logic                              reset,
    input  logic [7:0]                        op_code,
    input  logic                              op_code_valid,
    input  logic [7:0]                        operand,
    input  logic                              operand_valid,
    input  logic [15:0]                       operand_count,
    output logic                              palette_write,
    output display_pixel_pkg::palette_index_t palette_index,
    output display_pixel_pkg::color_t         palette_color,
    output logic                              clear_pulse,
    output logic                              show_pulse,
    sprite_if.decoder                         sprite
);

    logic op_code_valid_q;  // For edge detection
    logic command_start;
    logic color_operand;
    logic sprite_operand;

    display_cmd_pkg::sprite_setup_t setup_q;
    logic                           setup_valid_q;
    logic                           data_valid_q;
    logic [7:0]                     data_q;

    assign command_start = op_code_valid && !op_code_valid_q;

    assign color_operand = op_code_valid && operand_valid
                           && op_code == display_cmd_pkg::op_assign_color;
    assign sprite_operand = op_code_valid && operand_valid
                            && op_code == display_cmd_pkg::op_draw_sprite;

    // Pulses, one cycle after their cause
    always_ff @(posedge clock_in) begin
        if (reset) begin
            op_code_valid_q <= 1'b0;
            clear_pulse     <= 1'b0;
            show_pulse      <= 1'b0;
            palette_write   <= 1'b0;
            setup_valid_q   <= 1'b0;
            data_valid_q    <= 1'b0;
        end else begin
            op_code_valid_q <= op_code_valid;
            clear_pulse     <= command_start && op_code == display_cmd_pkg::op_clear_buffer;
            show_pulse      <= command_start && op_code == display_cmd_pkg::op_show_buffer;
            palette_write   <= color_operand
                               && operand_count == display_cmd_pkg::color_operand_count;
            setup_valid_q   <= sprite_operand
                               && operand_count == display_cmd_pkg::setup_operand_count;
            data_valid_q    <= sprite_operand
                               && operand_count > display_cmd_pkg::setup_operand_count;
        end
    end

    // Fields collect as operands arrive
    always_ff @(posedge clock_in) begin
        if (color_operand) begin
            case (operand_count)
                16'd1: palette_index <= operand[3:0];
                16'd2: palette_color.luma <= operand[7:4];
                16'd3: palette_color.cb <= operand[7:5];
                16'd4: palette_color.cr <= operand[7:5];
                default: ;  // Extra bytes ignored
            endcase
        end

        if (sprite_operand) begin
            case (operand_count)
                16'd1: setup_q.x[9:8] <= operand[1:0];
                16'd2: setup_q.x[7:0] <= operand;
                16'd3: setup_q.y[9:8] <= operand[1:0];
                16'd4: setup_q.y[7:0] <= operand;
                16'd5: setup_q.width[9:8] <= operand[1:0];
                16'd6: setup_q.width[7:0] <= operand;
                16'd7: setup_q.total_colors <= operand[4:0];
                16'd8: setup_q.palette_offset <= operand[3:0];
                default: data_q <= operand;  // Sprite pixel data
            endcase
        end
    end

    assign sprite.setup_valid = setup_valid_q;
    assign sprite.setup       = setup_q;
    assign sprite.data_valid  = data_valid_q;
    assign sprite.data        = data_q;

endmodule

/* hw/sprite_engine.sv */
// Sprite engine
// Unpacks sprite bytes into back-buffer pixel writes
module sprite_engine #(
    parameter int screen_width  = 64,
    parameter int screen_height = 32
) (
    input  logic          clock_in,
    input  logic          reset,
    sprite_if.engine      sprite,
    pixel_write_if.source pixels,
    output logic          drawing_busy
);

    display_cmd_pkg::sprite_setup_t setup_q;

    logic [7:0]  shift_q;        // Byte being unpacked, MSB pixel first
    logic        active_q;
    logic [7:0]  hold_q;         // Next byte, waiting
    logic        hold_valid_q;
    logic [2:0]  pixel_count_q;
    logic [10:0] cursor_x_q;     // Extra bit keeps overflow off screen
    logic [10:0] cursor_y_q;
    logic [9:0]  column_q;

    logic [2:0]                        bpp;
    logic [2:0]                        last_pixel;
    display_pixel_pkg::palette_index_t pixel_value;
    logic                              in_screen;
    logic                              byte_done;
    logic                              row_done;
    logic                              load_from_hold;
    logic                              load_direct;
    logic                              to_hold;

    always_comb begin
        bpp = display_pixel_pkg::bits_per_pixel(setup_q.total_colors);
        case (bpp)
            3'd1: begin
                pixel_value = {3'b000, shift_q[7]};
                last_pixel  = 3'd7;
            end
            3'd2: begin
                pixel_value = {2'b00, shift_q[7:6]};
                last_pixel  = 3'd3;
            end
            default: begin
                pixel_value = shift_q[7:4];
                last_pixel  = 3'd1;
            end
        endcase
    end

    assign in_screen = cursor_x_q < 11'(screen_width) && cursor_y_q < 11'(screen_height);
    assign byte_done = active_q && pixel_count_q == last_pixel;
    assign row_done  = column_q == setup_q.width - 10'd1;

    // Byte hand-over between input, holding register and shifter
    assign load_from_hold = byte_done && hold_valid_q;
    assign load_direct    = sprite.data_valid && (!active_q || (byte_done && !hold_valid_q));
    assign to_hold        = sprite.data_valid && !load_direct;

    always_ff @(posedge clock_in) begin
        if (reset) begin
            active_q      <= 1'b0;
            hold_valid_q  <= 1'b0;
            pixel_count_q <= 3'd0;
        end else begin
            active_q      <= load_direct || load_from_hold || (active_q && !byte_done);
            hold_valid_q  <= to_hold || (hold_valid_q && !load_from_hold);
            pixel_count_q <= (!active_q || byte_done) ? 3'd0 : pixel_count_q + 3'd1;
        end
    end

    always_ff @(posedge clock_in) begin
        if (to_hold) begin
            hold_q <= sprite.data;
        end

        if (load_from_hold) begin
            shift_q <= hold_q;
        end else if (load_direct) begin
            shift_q <= sprite.data;
        end else if (active_q) begin
            shift_q <= shift_q << bpp;
        end

        // Cursor walks the sprite row by row
        if (sprite.setup_valid) begin
            setup_q    <= sprite.setup;
            cursor_x_q <= {1'b0, sprite.setup.x};
            cursor_y_q <= {1'b0, sprite.setup.y};
            column_q   <= 10'd0;
        end else if (active_q) begin
            if (row_done) begin
                column_q   <= 10'd0;
                cursor_x_q <= {1'b0, setup_q.x};
                cursor_y_q <= cursor_y_q + 11'd1;
            end else begin
                column_q   <= column_q + 10'd1;
                cursor_x_q <= cursor_x_q + 11'd1;
            end
        end
    end

    // Zero is transparent, clipped pixels never leave
    assign pixels.write_enable = active_q && pixel_value != 4'd0 && in_screen;
    assign pixels.x            = cursor_x_q[9:0];
    assign pixels.y            = cursor_y_q[9:0];
    assign pixels.index        = pixel_value + setup_q.palette_offset;  // Wraps mod 16

    assign drawing_busy = active_q || hold_valid_q;

endmodule

/* hw/pixel_memory.sv */
// Simple dual-port memory
module pixel_memory #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 16
) (
    input  logic                     clock_in,
    input  logic                     write_enable,
    input  logic [$clog2(depth)-1:0] write_address,
    input  entry_t                   write_data,
    input  logic [$clog2(depth)-1:0] read_address,
    output entry_t                   read_data
);

    entry_t storage [depth];

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            storage[write_address] <= write_data;
        end
    end

    // Registered read, old data on collision
    always_ff @(posedge clock_in) begin
        read_data <= storage[read_address];
    end

endmodule

/* hw/buffer_manager.sv */
// Buffer manager
// Palette, double pixel buffer and readout
module buffer_manager #(
    parameter int screen_width  = 64,
    parameter int screen_height = 32
) (
    input  logic                              clock_in,
    input  logic                              reset,
    pixel_write_if.sink                       pixels,
    input  logic                              palette_write,
    input  display_pixel_pkg::palette_index_t palette_index,
    input  display_pixel_pkg::color_t         palette_color,
    input  logic                              clear_pulse,
    input  logic                              show_pulse,
    input  display_pixel_pkg::coord_t         read_x,
    input  display_pixel_pkg::coord_t         read_y,
    output display_pixel_pkg::color_t         read_color,
    output logic                              clear_busy
);

    localparam int buffer_depth  = screen_width * screen_height;
    localparam int address_bits  = $clog2(buffer_depth);
    localparam int palette_depth = 2 ** $bits(display_pixel_pkg::palette_index_t);

    typedef logic [address_bits-1:0] address_t;

    logic     front_select_q;  // High when buffer one is displayed
    logic     read_front_q;    // Front select seen by the buffer read
    address_t clear_address_q;

    address_t                          write_address;
    address_t                          read_address;
    logic                              back_write;
    display_pixel_pkg::palette_index_t back_data;
    display_pixel_pkg::palette_index_t buffer_zero_data;
    display_pixel_pkg::palette_index_t buffer_one_data;
    display_pixel_pkg::palette_index_t front_index;

    // Clear sweep takes priority over sprite pixels
    always_comb begin
        if (clear_busy) begin
            write_address = clear_address_q;
            back_data     = '0;
        end else begin
            write_address = address_t'(pixels.y * screen_width + pixels.x);
            back_data     = pixels.index;
        end
        back_write   = clear_busy || pixels.write_enable;
        read_address = address_t'(read_y * screen_width + read_x);
    end

    always_ff @(posedge clock_in) begin
        if (reset) begin
            front_select_q  <= 1'b0;
            read_front_q    <= 1'b0;
            clear_busy      <= 1'b0;
            clear_address_q <= '0;
        end else begin
            if (show_pulse) begin
                front_select_q <= !front_select_q;
            end
            read_front_q <= front_select_q;

            if (clear_pulse) begin
                clear_busy      <= 1'b1;
                clear_address_q <= '0;
            end else if (clear_busy) begin
                clear_address_q <= clear_address_q + 1'b1;
                if (clear_address_q == address_t'(buffer_depth - 1)) begin
                    clear_busy <= 1'b0;  // Last address written this cycle
                end
            end
        end
    end

    pixel_memory #(
        .entry_t (display_pixel_pkg::palette_index_t),
        .depth   (buffer_depth)
    ) buffer_zero (
        .clock_in      (clock_in),
        .write_enable  (back_write && front_select_q),
        .write_address (write_address),
        .write_data    (back_data),
        .read_address  (read_address),
        .read_data     (buffer_zero_data)
    );

    pixel_memory #(
        .entry_t (display_pixel_pkg::palette_index_t),
        .depth   (buffer_depth)
    ) buffer_one (
        .clock_in      (clock_in),
        .write_enable  (back_write && !front_select_q),
        .write_address (write_address),
        .write_data    (back_data),
        .read_address  (read_address),
        .read_data     (buffer_one_data)
    );

    // Second readout stage looks up the color
    assign front_index = read_front_q ? buffer_one_data : buffer_zero_data;

    pixel_memory #(
        .entry_t (display_pixel_pkg::color_t),
        .depth   (palette_depth)
    ) palette (
        .clock_in      (clock_in),
        .write_enable  (palette_write),
        .write_address (palette_index),
        .write_data    (palette_color),
        .read_address  (front_index),
        .read_data     (read_color)
    );

endmodule

/* hw/display_core.sv */
// Display drawing core
module display_core #(
    parameter int screen_width  = 64,
    parameter int screen_height = 32
) (
    input  logic                      clock_in,
    input  logic                      reset,
    input  logic [7:0]                op_code,
    input  logic                      op_code_valid,
    input  logic [7:0]                operand,
    input  logic                      operand_valid,
    input  logic [15:0]               operand_count,
    input  display_pixel_pkg::coord_t read_x,
    input  display_pixel_pkg::coord_t read_y,
    output display_pixel_pkg::color_t read_color,
    output logic                      clear_busy,
    output logic                      drawing_busy
);

    sprite_if      sprite_bus ();
    pixel_write_if pixel_bus ();

    logic                              palette_write;
    display_pixel_pkg::palette_index_t palette_index;
    display_pixel_pkg::color_t         palette_color;
    logic                              clear_pulse;
    logic                              show_pulse;

    command_decoder decoder (
        .clock_in      (clock_in),
        .reset         (reset),
        .op_code       (op_code),
        .op_code_valid (op_code_valid),
        .operand       (operand),
        .operand_valid (operand_valid),
        .operand_count (operand_count),
        .palette_write (palette_write),
        .palette_index (palette_index),
        .palette_color (palette_color),
        .clear_pulse   (clear_pulse),
        .show_pulse    (show_pulse),
        .sprite        (sprite_bus.decoder)
    );

    sprite_engine #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    ) engine (
        .clock_in     (clock_in),
        .reset        (reset),
        .sprite       (sprite_bus.engine),
        .pixels       (pixel_bus.source),
        .drawing_busy (drawing_busy)
    );

    buffer_manager #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    ) buffers (
        .clock_in      (clock_in),
        .reset         (reset),
        .pixels        (pixel_bus.sink),
        .palette_write (palette_write),
        .palette_index (palette_index),
        .palette_color (palette_color),
        .clear_pulse   (clear_pulse),
        .show_pulse    (show_pulse),
        .read_x        (read_x),
        .read_y        (read_y),
        .read_color    (read_color),
        .clear_busy    (clear_busy)
    );

endmodule

/* dv/display_tb_asserts.sv */
// Buffer manager checks
module display_tb_asserts #(
    parameter int screen_width  = 64,
    parameter int screen_height = 32
) (
    input logic clock_in,
    input logic reset,
    input logic clear_pulse,
    input logic show_pulse,
    input logic clear_busy,
    input logic front_select,
    input logic pixel_write
);

    localparam int sweep_length = screen_width * screen_height;

    int busy_cycles;
    int failure_count = 0;

    always_ff @(posedge clock_in) begin
        if (reset || !clear_busy) begin
            busy_cycles <= 0;
        end else begin
            busy_cycles <= busy_cycles + 1;  // Cycles of the running sweep
        end
    end

    clear_starts: assert property (@(posedge clock_in) disable iff (reset)
        clear_pulse |=> clear_busy)
        else begin
            failure_count++;
            $error("clear_busy did not follow clear_pulse");
        end

    clear_bounded: assert property (@(posedge clock_in) disable iff (reset)
        clear_busy |-> busy_cycles < sweep_length)
        else begin
            failure_count++;
            $error("clear sweep runs past the buffer size");
        end

    clear_length: assert property (@(posedge clock_in) disable iff (reset)
        $fell(clear_busy) |-> busy_cycles == sweep_length)
        else begin
            failure_count++;
            $error("clear sweep ended after %0d cycles", busy_cycles);
        end

    // Sprite pixels must not collide with the sweep
    no_write_in_clear: assert property (@(posedge clock_in) disable iff (reset)
        !(clear_busy && pixel_write))
        else begin
            failure_count++;
            $error("pixel write during clear sweep");
        end

    show_toggles: assert property (@(posedge clock_in) disable iff (reset)
        show_pulse |=> front_select != $past(front_select))
        else begin
            failure_count++;
            $error("show_pulse did not swap the buffers");
        end

    front_steady: assert property (@(posedge clock_in) disable iff (reset)
        !show_pulse |=> $stable(front_select))
        else begin
            failure_count++;
            $error("front select changed without show_pulse");
        end

endmodule

bind buffer_manager display_tb_asserts #(
    .screen_width  (screen_width),
    .screen_height (screen_height)
) asserts (
    .clock_in     (clock_in),
    .reset        (reset),
    .clear_pulse  (clear_pulse),
    .show_pulse   (show_pulse),
    .clear_busy   (clear_busy),
    .front_select (front_select_q),
    .pixel_write  (pixels.write_enable)
);

/* dv/display_tb.sv */
// Display core testbench
module display_tb;

    localparam int screen_width  = 64;
    localparam int screen_height = 32;
    localparam int pixel_total   = screen_width * screen_height;
    localparam int script_count  = 23;

    // One command per row, sprite data bytes come from $urandom
    typedef struct packed {
        int          test;
        logic [7:0]  op;
        int          header_count;
        logic [63:0] header;  // Operand 1 in the top byte
        int          count;   // Data bytes, or palette entries for assign color
        bit          scan_after;
    } script_t;

    script_t scripts [script_count] = '{
        '{1, display_cmd_pkg::op_assign_color, 4, 64'h0, 16, 1'b0},
        '{1, display_cmd_pkg::op_clear_buffer, 0, 64'h0, 0, 1'b0},
        '{1, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1},
        '{2, display_cmd_pkg::op_clear_buffer, 0, 64'h0, 0, 1'b0},
        '{2, display_cmd_pkg::op_draw_sprite, 8, 64'h000a_0004_000c_0205, 6, 1'b0},  // 1 bpp
        '{2, display_cmd_pkg::op_draw_sprite, 8, 64'h000e_0005_0009_0109, 5, 1'b0},  // Overlap
        '{2, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1},
        '{3, display_cmd_pkg::op_clear_buffer, 0, 64'h0, 0, 1'b0},
        '{3, display_cmd_pkg::op_draw_sprite, 8, 64'h0003_000a_000a_040e, 10, 1'b0}, // 2 bpp
        '{3, display_cmd_pkg::op_draw_sprite, 8, 64'h0014_0002_0006_1007, 12, 1'b0}, // 4 bpp
        '{3, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1},
        '{4, display_cmd_pkg::op_clear_buffer, 0, 64'h0, 0, 1'b0},
        '{4, display_cmd_pkg::op_draw_sprite, 8, 64'h003c_001d_0008_100b, 20, 1'b0}, // Edges
        '{4, display_cmd_pkg::op_draw_sprite, 8, 64'h003e_001f_0004_0203, 2, 1'b0},
        '{4, display_cmd_pkg::op_draw_sprite, 8, 64'h0100_0002_0004_0201, 2, 1'b0},  // x 256
        '{4, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1},
        '{5, display_cmd_pkg::op_draw_sprite, 8, 64'h001e_000c_0005_0301, 5, 1'b1},  // Back only
        '{5, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1},
        '{5, display_cmd_pkg::op_clear_buffer, 0, 64'h0, 0, 1'b0},
        '{5, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1},
        '{6, 8'h13, 8, 64'h0001_0001_0010_1004, 4, 1'b0},
        '{6, 8'h15, 0, 64'h0, 0, 1'b1},
        '{6, display_cmd_pkg::op_show_buffer, 0, 64'h0, 0, 1'b1}
    };

    logic        clock_in = 1'b0;
    logic        reset;
    logic [7:0]  op_code;
    logic        op_code_valid;
    logic [7:0]  operand;
    logic        operand_valid;
    logic [15:0] operand_count;
    logic [9:0]  read_x;
    logic [9:0]  read_y;
    logic [9:0]  read_color;
    logic        clear_busy;
    logic        drawing_busy;

    // Reference model
    logic [9:0] ref_palette [16];
    logic [3:0] ref_buffer [2][pixel_total];
    int         ref_front = 0;
    int         spr_x;
    int         spr_y;
    int         spr_width;
    int         spr_bits;
    int         spr_offset;
    int         cur_x;
    int         cur_y;
    int         column;

    int cycle_count = 0;
    int cycle_limit = 0;
    int error_count = 0;
    int test_errors = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    display_core DUT (
        .clock_in      (clock_in),
        .reset         (reset),
        .op_code       (op_code),
        .op_code_valid (op_code_valid),
        .operand       (operand),
        .operand_valid (operand_valid),
        .operand_count (operand_count),
        .read_x        (read_x),
        .read_y        (read_y),
        .read_color    (read_color),
        .clear_busy    (clear_busy),
        .drawing_busy  (drawing_busy)
    );

    always #10 clock_in = !clock_in;

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stayed busy", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic int cycle_budget();
        int total;
        int r;
        total = 20;
        for (r = 0; r < script_count; r++) begin
            total += 30;
            if (scripts[r].op == display_cmd_pkg::op_assign_color) begin
                total += scripts[r].count * 60;
            end else if (scripts[r].op == display_cmd_pkg::op_clear_buffer) begin
                total += pixel_total + 20;
            end else begin
                total += (scripts[r].header_count + scripts[r].count) * 11 + 20;
            end
            if (scripts[r].scan_after) begin
                total += pixel_total + 10;
            end
        end
        return total + total / 2;  // Margin for idle cycles
    endfunction

    function automatic int pixel_bits(input int colors);
        if (colors <= 2) begin
            return 1;
        end else if (colors <= 4) begin
            return 2;
        end
        return 4;
    endfunction

    // MSB pixel first, zero is transparent
    task automatic model_data_byte(input logic [7:0] value);
        int k;
        int v;
        for (k = 0; k < 8 / spr_bits; k++) begin
            v = (int'(value) >> (8 - spr_bits * (k + 1))) & ((1 << spr_bits) - 1);
            if (v != 0 && cur_x < screen_width && cur_y < screen_height) begin
                ref_buffer[1 - ref_front][cur_y * screen_width + cur_x] = 4'((v + spr_offset) % 16);
            end
            column++;
            cur_x++;
            if (column == spr_width) begin
                column = 0;
                cur_x  = spr_x;
                cur_y++;
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] value, input int position);
        repeat (9) @(negedge clock_in);
        operand       = value;
        operand_count = 16'(position);
        operand_valid = 1'b1;
        @(negedge clock_in);
        operand_valid = 1'b0;
    endtask

    task automatic start_command(input logic [7:0] op);
        @(negedge clock_in);
        op_code       = op;
        op_code_valid = 1'b1;
    endtask

    task automatic end_command();
        repeat (4) @(negedge clock_in);
        op_code_valid = 1'b0;
        repeat (3) @(negedge clock_in);
    endtask

    task automatic run_script(input script_t s);
        int         e;
        int         n;
        logic [7:0] index_byte;
        logic [7:0] luma_byte;
        logic [7:0] cb_byte;
        logic [7:0] cr_byte;
        logic [7:0] data;
        logic       busy_expected;
        if (s.op == display_cmd_pkg::op_assign_color) begin
            for (e = 0; e < s.count; e++) begin  // One command per entry
                index_byte = s.header[63:56] + 8'(e);
                luma_byte  = {4'(e), 4'($urandom)};  // Distinct luma per entry
                cb_byte    = 8'($urandom);
                cr_byte    = 8'($urandom);
                start_command(s.op);
                send_byte(index_byte, 1);
                send_byte(luma_byte, 2);
                send_byte(cb_byte, 3);
                send_byte(cr_byte, 4);
                end_command();
                ref_palette[index_byte[3:0]] = {luma_byte[7:4], cb_byte[7:5], cr_byte[7:5]};
            end
        end else if (s.op == display_cmd_pkg::op_clear_buffer) begin
            start_command(s.op);
            end_command();
            if (!clear_busy) begin
                $display("clear_busy did not rise after the clear command at %0t", $time);
                test_errors++;
            end
            while (clear_busy) @(negedge clock_in);
            for (n = 0; n < pixel_total; n++) begin
                ref_buffer[1 - ref_front][n] = 4'd0;
            end
        end else if (s.op == display_cmd_pkg::op_show_buffer) begin
            start_command(s.op);
            end_command();
            ref_front = 1 - ref_front;
        end else begin
            start_command(s.op);
            for (n = 1; n <= s.header_count; n++) begin
                send_byte(s.header[71 - 8 * n -: 8], n);
            end
            if (s.op == display_cmd_pkg::op_draw_sprite) begin
                spr_x      = int'(s.header[57:48]);
                spr_y      = int'(s.header[41:32]);
                spr_width  = int'(s.header[25:16]);
                spr_bits   = pixel_bits(int'(s.header[12:8]));
                spr_offset = int'(s.header[3:0]);
                cur_x      = spr_x;
                cur_y      = spr_y;
                column     = 0;
            end
            for (n = 0; n < s.count; n++) begin
                data = 8'($urandom);
                send_byte(data, 9 + n);
                @(negedge clock_in);  // Byte unpacks two cycles after its strobe
                busy_expected = (s.op == display_cmd_pkg::op_draw_sprite);
                if (drawing_busy !== busy_expected) begin
                    $display("FAILED at %0t: drawing_busy is %b, expected %b",
                             $time, drawing_busy, busy_expected);
                    test_errors++;
                end
                if (s.op == display_cmd_pkg::op_draw_sprite) begin
                    model_data_byte(data);
                end
            end
            repeat (3) @(negedge clock_in);  // Let the last byte reach the engine
            while (drawing_busy) @(negedge clock_in);
            end_command();
        end
    endtask

    // Readout is two cycles deep, check runs two coordinates behind
    task automatic scan_front();
        int         i;
        int         address;
        logic [9:0] expected;
        for (i = 0; i < pixel_total + 2; i++) begin
            @(negedge clock_in);
            if (i >= 2) begin
                address  = i - 2;
                expected = ref_palette[ref_buffer[ref_front][address]];
                check_count++;
                if (read_color !== expected) begin
                    test_errors++;
                    if (test_errors <= 5) begin
                        $display("FAILED at %0t: read_color at x=%0d y=%0d is %h, expected %h",
                                 $time, address % screen_width, address / screen_width,
                                 read_color, expected);
                    end
                end
            end
            if (i < pixel_total) begin
                read_x = 10'(i % screen_width);
                read_y = 10'(i / screen_width);
            end
        end
    endtask

    task automatic finish_test(input int test);
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("test %0d passed", test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", test, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int r;
        int current_test;
        void'($urandom(32'h80a5_8bc0));
        reset         = 1'b1;
        op_code       = 8'h00;
        op_code_valid = 1'b0;
        operand       = 8'h00;
        operand_valid = 1'b0;
        operand_count = 16'd0;
        read_x        = 10'd0;
        read_y        = 10'd0;
        cycle_limit   = cycle_budget();
        repeat (8) @(negedge clock_in);
        reset = 1'b0;

        current_test = scripts[0].test;
        for (r = 0; r < script_count; r++) begin
            if (scripts[r].test != current_test) begin
                finish_test(current_test);
                current_test = scripts[r].test;
            end
            run_script(scripts[r]);
            if (scripts[r].scan_after) begin
                scan_front();
            end
        end
        finish_test(current_test);

        if (DUT.buffers.asserts.failure_count != 0) begin
            $display("Assertions on buffer_manager failed %0d times",
                     DUT.buffers.asserts.failure_count);
            error_count += DUT.buffers.asserts.failure_count;
        end
        $display("tests %0d, failed %0d, pixel checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/display_cmd_pkg.sv
hw/display_pixel_pkg.sv
hw/display_if.sv
hw/command_decoder.sv
hw/sprite_engine.sv
hw/pixel_memory.sv
hw/buffer_manager.sv
hw/display_core.sv
dv/display_tb_asserts.sv
dv/display_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module display_tb -Mdir build -o display_tb
	./build/display_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf build sim.log
